// ==== execPkg.sv ====
`default_nettype none

package execPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;

    localparam word_t InsnSize = 32'd4;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOp_e;

    typedef enum logic [2:0] {
        branchEqual,
        branchNotEqual,
        branchLessThan,
        branchGreaterEqual,
        branchUnsignedLessThan,
        branchUnsignedGreaterEqual,
        branchAlways
    } branchType_e;

    typedef enum logic [2:0] {
        mulDivMul,
        mulDivMulh,
        mulDivMulhu,
        mulDivDiv,
        mulDivDivu,
        mulDivRem,
        mulDivRemu
    } mulDivOp_e;

    typedef enum logic [1:0] {
        aluSrc1Reg,
        aluSrc1Pc,
        aluSrc1Zero
    } aluSrc1_e;

    typedef enum logic {
        aluSrc2Reg,
        aluSrc2Imm
    } aluSrc2_e;

    typedef enum logic [1:0] {
        resultAlu,
        resultMulDiv,
        resultNextPc
    } resultSrc_e;

    // decoded operation as handed over by the issuer
    typedef struct packed {
        aluOp_e aluOp;
        aluSrc1_e aluSrc1;
        aluSrc2_e aluSrc2;
        resultSrc_e resultSrc;
        mulDivOp_e mulDivOp;
        branchType_e branchType;
        logic isBranch;
        logic regWrite;
        word_t imm;
        word_t pc;
        regAddr_t src1;
        regAddr_t src2;
        regAddr_t dst;
    } op_t;

    typedef struct packed {
        logic valid;
        op_t op;
        word_t srcValue1;
        word_t srcValue2;
    } readOut_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        regAddr_t dst;
        logic regWrite;
        word_t value;
        logic branchTaken;
        word_t branchTarget;
    } retire_t;

endpackage

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic clk,
    input  logic rstN,
    input  execPkg::regAddr_t readAddr1,
    input  execPkg::regAddr_t readAddr2,
    output execPkg::word_t readValue1,
    output execPkg::word_t readValue2,
    input  logic writeEnable,
    input  execPkg::regAddr_t writeAddr,
    input  execPkg::word_t writeValue
);

    execPkg::word_t regs [32];
    logic writeLive;

    // x0 never takes a write
    assign writeLive = writeEnable && (writeAddr != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeAddr] <= writeValue;
        end
    end

    // write-through so a same-cycle reader sees the new value
    always_comb begin
        readValue1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
        readValue2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
        if (writeLive && (readAddr1 == writeAddr)) begin
            readValue1 = writeValue;
        end
        if (writeLive && (readAddr2 == writeAddr)) begin
            readValue2 = writeValue;
        end
    end

endmodule

`default_nettype wire

// ==== regReadStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module regReadStage (
    input  logic clk,
    input  logic rstN,
    input  logic issueValid,
    input  execPkg::op_t issueOp,
    input  execPkg::word_t readValue1,
    input  execPkg::word_t readValue2,
    input  logic stall,
    input  logic kill,
    output execPkg::readOut_t readOut
);

    logic validReg;
    execPkg::op_t opReg;
    execPkg::word_t srcValue1Reg;
    execPkg::word_t srcValue2Reg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validReg <= 1'b0;
        end else if (kill) begin
            // younger op behind a taken branch is dropped
            validReg <= 1'b0;
        end else if (!stall) begin
            validReg <= issueValid;
        end
    end

    // operands are held with the op while execute stalls
    always_ff @(posedge clk) begin
        if (!stall) begin
            opReg <= issueOp;
            srcValue1Reg <= readValue1;
            srcValue2Reg <= readValue2;
        end
    end

    always_comb begin
        readOut.valid = validReg;
        readOut.op = opReg;
        readOut.srcValue1 = srcValue1Reg;
        readOut.srcValue2 = srcValue2Reg;
    end

endmodule

`default_nettype wire

// ==== mulDivUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  execPkg::mulDivOp_e mulDivOp,
    input  execPkg::word_t a,
    input  execPkg::word_t b,
    output logic done,
    output execPkg::word_t result
);

    typedef enum logic [1:0] {
        stateIdle,
        stateRun,
        stateFix
    } state_e;

    state_e state;
    logic [4:0] stepCount;
    execPkg::mulDivOp_e opReg;
    // hi half is partial product or remainder, lo half multiplier or quotient
    logic [63:0] acc;
    execPkg::word_t operandB;
    logic negate;
    logic divZero;

    logic isSigned, isDivide, signA, signB;
    execPkg::word_t absA, absB;
    logic [32:0] addSum, trialShift, trialDiff;
    execPkg::word_t negLo, negHi;
    logic [63:0] negAcc;

    always_comb begin
        isSigned = (mulDivOp == execPkg::mulDivMulh) || (mulDivOp == execPkg::mulDivDiv)
            || (mulDivOp == execPkg::mulDivRem);
        isDivide = (opReg == execPkg::mulDivDiv) || (opReg == execPkg::mulDivDivu)
            || (opReg == execPkg::mulDivRem) || (opReg == execPkg::mulDivRemu);
        signA = isSigned && a[31];
        signB = isSigned && b[31];
        absA = signA ? -a : a;
        absB = signB ? -b : b;

        addSum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, operandB} : 33'd0);
        trialShift = {acc[63:31]};
        trialDiff = trialShift - {1'b0, operandB};

        negAcc = -acc;
        negLo = -acc[31:0];
        negHi = -acc[63:32];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stateIdle;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            unique case (state)
                stateIdle: if (start) state <= stateRun;
                stateRun: if (stepCount == 5'd31) state <= stateFix;
                stateFix: begin
                    state <= stateIdle;
                    done <= 1'b1;
                end
                default: state <= stateIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stateIdle && start) begin
            opReg <= mulDivOp;
            acc <= {32'd0, absA};
            operandB <= absB;
            stepCount <= '0;
            divZero <= (b == '0);
            // rem follows the dividend sign, the rest the product of signs
            negate <= (mulDivOp == execPkg::mulDivRem) ? signA : (signA ^ signB);
        end else if (state == stateRun) begin
            stepCount <= stepCount + 5'd1;
            if (!isDivide) begin
                acc <= {addSum, acc[31:1]};
            end else if (!trialDiff[32]) begin
                acc <= {trialDiff[31:0], acc[30:0], 1'b1};
            end else begin
                acc <= {trialShift[31:0], acc[30:0], 1'b0};
            end
        end else if (state == stateFix) begin
            // most negative / -1 falls out of the sign fix with no special case
            unique case (opReg)
                execPkg::mulDivMul: result <= acc[31:0];
                execPkg::mulDivMulh: result <= negate ? negAcc[63:32] : acc[63:32];
                execPkg::mulDivMulhu: result <= acc[63:32];
                execPkg::mulDivDiv: result <= divZero ? '1 : (negate ? negLo : acc[31:0]);
                execPkg::mulDivDivu: result <= divZero ? '1 : acc[31:0];
                execPkg::mulDivRem: result <= negate ? negHi : acc[63:32];
                execPkg::mulDivRemu: result <= acc[63:32];
                default: result <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic clk,
    input  logic rstN,
    input  execPkg::readOut_t readOut,
    input  logic mulDivDone,
    input  execPkg::word_t mulDivResult,
    output logic mulDivStart,
    output execPkg::mulDivOp_e mulDivOp,
    output execPkg::word_t mulDivA,
    output execPkg::word_t mulDivB,
    output logic stall,
    output logic kill,
    output execPkg::retire_t retire
);

    function automatic execPkg::word_t aluCompute(execPkg::aluOp_e aluOp,
                                                  execPkg::word_t x, execPkg::word_t y);
        unique case (aluOp)
            execPkg::aluAdd: return x + y;
            execPkg::aluSub: return x - y;
            execPkg::aluSll: return x << y[4:0];
            execPkg::aluSlt: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            execPkg::aluSltu: return (x < y) ? 32'd1 : 32'd0;
            execPkg::aluXor: return x ^ y;
            execPkg::aluSrl: return x >> y[4:0];
            execPkg::aluSra: return $unsigned($signed(x) >>> y[4:0]);
            execPkg::aluOr: return x | y;
            execPkg::aluAnd: return x & y;
            default: return '0;
        endcase
    endfunction

    function automatic logic branchCompare(execPkg::branchType_e branchType,
                                           execPkg::word_t x, execPkg::word_t y);
        unique case (branchType)
            execPkg::branchEqual: return x == y;
            execPkg::branchNotEqual: return x != y;
            execPkg::branchLessThan: return $signed(x) < $signed(y);
            execPkg::branchGreaterEqual: return $signed(x) >= $signed(y);
            execPkg::branchUnsignedLessThan: return x < y;
            execPkg::branchUnsignedGreaterEqual: return x >= y;
            execPkg::branchAlways: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    execPkg::op_t op;
    logic retireWrites, fwd1, fwd2;
    execPkg::word_t srcValue1, srcValue2;
    execPkg::word_t aluIn1, aluIn2, aluResult, resultValue;
    logic isMulDiv, started, branchTaken;

    always_comb begin
        op = readOut.op;

        // the retire register is the only result not yet in the register file
        retireWrites = retire.valid && retire.regWrite && (retire.dst != '0);
        fwd1 = retireWrites && (retire.dst == op.src1);
        fwd2 = retireWrites && (retire.dst == op.src2);
        srcValue1 = fwd1 ? retire.value : readOut.srcValue1;
        srcValue2 = fwd2 ? retire.value : readOut.srcValue2;

        unique case (op.aluSrc1)
            execPkg::aluSrc1Reg: aluIn1 = srcValue1;
            execPkg::aluSrc1Pc: aluIn1 = op.pc;
            execPkg::aluSrc1Zero: aluIn1 = '0;
            default: aluIn1 = '0;
        endcase
        aluIn2 = (op.aluSrc2 == execPkg::aluSrc2Imm) ? op.imm : srcValue2;
        aluResult = aluCompute(op.aluOp, aluIn1, aluIn2);

        unique case (op.resultSrc)
            execPkg::resultAlu: resultValue = aluResult;
            execPkg::resultMulDiv: resultValue = mulDivResult;
            execPkg::resultNextPc: resultValue = op.pc + execPkg::InsnSize;
            default: resultValue = '0;
        endcase

        branchTaken = readOut.valid && op.isBranch
            && branchCompare(op.branchType, srcValue1, srcValue2);
    end

    // mul/div holds the stage until the unit reports done
    assign isMulDiv = readOut.valid && (op.resultSrc == execPkg::resultMulDiv);
    assign stall = isMulDiv && !mulDivDone;
    assign mulDivStart = isMulDiv && !started;
    assign mulDivOp = op.mulDivOp;
    assign mulDivA = srcValue1;
    assign mulDivB = srcValue2;
    assign kill = branchTaken && !stall;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            started <= 1'b0;
        end else if (mulDivStart) begin
            started <= 1'b1;
        end else if (mulDivDone) begin
            started <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            retire.valid <= 1'b0;
            retire.branchTaken <= 1'b0;
        end else begin
            // bubble while stalled
            retire.valid <= readOut.valid && !stall;
            retire.branchTaken <= branchTaken && !stall;
        end
        retire.pc <= op.pc;
        retire.dst <= op.dst;
        retire.regWrite <= op.regWrite;
        retire.value <= resultValue;
        retire.branchTarget <= aluResult;
    end

endmodule

`default_nettype wire

// ==== execCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module execCore (
    input  logic clk,
    input  logic rstN,
    input  logic issueValid,
    input  execPkg::op_t issueOp,
    output logic stall,
    output execPkg::retire_t retire
);

    execPkg::word_t readValue1, readValue2;
    execPkg::readOut_t readOut;
    logic kill;
    logic mulDivStart, mulDivDone;
    execPkg::mulDivOp_e mulDivOp;
    execPkg::word_t mulDivA, mulDivB, mulDivResult;

    regFile i_regFile (
        .clk(clk),
        .rstN(rstN),
        .readAddr1(issueOp.src1),
        .readAddr2(issueOp.src2),
        .readValue1(readValue1),
        .readValue2(readValue2),
        .writeEnable(retire.valid && retire.regWrite && (retire.dst != '0)),
        .writeAddr(retire.dst),
        .writeValue(retire.value)
    );

    regReadStage i_regReadStage (
        .clk(clk),
        .rstN(rstN),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .readValue1(readValue1),
        .readValue2(readValue2),
        .stall(stall),
        .kill(kill),
        .readOut(readOut)
    );

    executeStage i_executeStage (
        .clk(clk),
        .rstN(rstN),
        .readOut(readOut),
        .mulDivDone(mulDivDone),
        .mulDivResult(mulDivResult),
        .mulDivStart(mulDivStart),
        .mulDivOp(mulDivOp),
        .mulDivA(mulDivA),
        .mulDivB(mulDivB),
        .stall(stall),
        .kill(kill),
        .retire(retire)
    );

    mulDivUnit i_mulDivUnit (
        .clk(clk),
        .rstN(rstN),
        .start(mulDivStart),
        .mulDivOp(mulDivOp),
        .a(mulDivA),
        .b(mulDivB),
        .done(mulDivDone),
        .result(mulDivResult)
    );

endmodule

`default_nettype wire

// ==== tbVectors.svh ====
// one call per table row: resultRow(op, value), branchRow(op, taken, target),
// killedRow(op) behind a taken branch, pushRow(op, retires, value, taken, target)
task automatic loadTable();
    // alu commands on immediates loaded through the zero source
    resultRow(loadOp(32'h100, 5'd1, 32'hffff_fff0), 32'hffff_fff0);
    resultRow(loadOp(32'h104, 5'd2, 32'h0000_0005), 32'h0000_0005);
    resultRow(loadOp(32'h108, 5'd3, 32'h8000_0000), 32'h8000_0000);
    resultRow(regOp(32'h10c, execPkg::aluAdd, 5'd4, 5'd1, 5'd2), 32'hffff_fff5);
    resultRow(regOp(32'h110, execPkg::aluSub, 5'd5, 5'd2, 5'd1), 32'h0000_0015);
    resultRow(immOp(32'h114, execPkg::aluSll, 5'd6, 5'd2, 32'd3), 32'h0000_0028);
    resultRow(immOp(32'h118, execPkg::aluSlt, 5'd7, 5'd1, 32'd1), 32'h0000_0001);
    resultRow(regOp(32'h11c, execPkg::aluSltu, 5'd8, 5'd2, 5'd1), 32'h0000_0001);
    resultRow(immOp(32'h120, execPkg::aluXor, 5'd9, 5'd1, 32'h0000_00ff), 32'hffff_ff0f);
    resultRow(immOp(32'h124, execPkg::aluSrl, 5'd10, 5'd3, 32'd4), 32'h0800_0000);
    resultRow(immOp(32'h128, execPkg::aluSra, 5'd11, 5'd1, 32'd2), 32'hffff_fffc);
    resultRow(immOp(32'h12c, execPkg::aluSra, 5'd12, 5'd3, 32'd31), 32'hffff_ffff);
    resultRow(immOp(32'h130, execPkg::aluOr, 5'd13, 5'd2, 32'h0000_0f00), 32'h0000_0f05);
    resultRow(regOp(32'h134, execPkg::aluAnd, 5'd14, 5'd1, 5'd9), 32'hffff_ff00);
    resultRow(regOp(32'h138, execPkg::aluSlt, 5'd15, 5'd2, 5'd1), 32'h0000_0000);
    // chain through forwarding and write-through, x0 stays zero
    resultRow(immOp(32'h13c, execPkg::aluAdd, 5'd16, 5'd2, 32'h10), 32'h0000_0015);
    resultRow(immOp(32'h140, execPkg::aluAdd, 5'd17, 5'd16, 32'h1), 32'h0000_0016);
    resultRow(regOp(32'h144, execPkg::aluAdd, 5'd18, 5'd16, 5'd17), 32'h0000_002b);
    resultRow(loadOp(32'h148, 5'd0, 32'h0000_1234), 32'h0000_1234);
    resultRow(regOp(32'h14c, execPkg::aluAdd, 5'd19, 5'd0, 5'd18), 32'h0000_002b);
    // multiply and divide, x21 = -7, x22 = 3, x25 = -1
    resultRow(loadOp(32'h150, 5'd21, 32'hffff_fff9), 32'hffff_fff9);
    resultRow(loadOp(32'h154, 5'd22, 32'h0000_0003), 32'h0000_0003);
    resultRow(loadOp(32'h158, 5'd25, 32'hffff_ffff), 32'hffff_ffff);
    resultRow(mdOp(32'h15c, execPkg::mulDivMul, 5'd26, 5'd21, 5'd22), 32'hffff_ffeb);
    resultRow(mdOp(32'h160, execPkg::mulDivMulh, 5'd27, 5'd21, 5'd22), 32'hffff_ffff);
    resultRow(mdOp(32'h164, execPkg::mulDivMulhu, 5'd28, 5'd21, 5'd22), 32'h0000_0002);
    resultRow(mdOp(32'h168, execPkg::mulDivMulh, 5'd29, 5'd3, 5'd3), 32'h4000_0000);
    resultRow(mdOp(32'h16c, execPkg::mulDivDiv, 5'd30, 5'd21, 5'd22), 32'hffff_fffe);
    resultRow(mdOp(32'h170, execPkg::mulDivRem, 5'd31, 5'd21, 5'd22), 32'hffff_ffff);
    resultRow(mdOp(32'h174, execPkg::mulDivDivu, 5'd26, 5'd21, 5'd22), 32'h5555_5553);
    resultRow(mdOp(32'h178, execPkg::mulDivRemu, 5'd27, 5'd21, 5'd2), 32'h0000_0004);
    resultRow(mdOp(32'h17c, execPkg::mulDivDiv, 5'd28, 5'd21, 5'd0), 32'hffff_ffff);
    resultRow(mdOp(32'h180, execPkg::mulDivRem, 5'd29, 5'd21, 5'd0), 32'hffff_fff9);
    resultRow(mdOp(32'h184, execPkg::mulDivDivu, 5'd30, 5'd21, 5'd0), 32'hffff_ffff);
    resultRow(mdOp(32'h188, execPkg::mulDivRemu, 5'd31, 5'd21, 5'd0), 32'hffff_fff9);
    resultRow(mdOp(32'h18c, execPkg::mulDivDiv, 5'd26, 5'd3, 5'd25), 32'h8000_0000);
    resultRow(mdOp(32'h190, execPkg::mulDivRem, 5'd27, 5'd3, 5'd25), 32'h0000_0000);
    resultRow(regOp(32'h194, execPkg::aluAdd, 5'd5, 5'd26, 5'd27), 32'h8000_0000);
    // each branch kind taken then not taken, x1 = -16, x2 = 5
    branchRow(branchOp(32'h198, execPkg::branchEqual, 5'd2, 5'd2, 32'h20), 1'b1, 32'h1b8);
    killedRow(loadOp(32'h19c, 5'd7, 32'h0000_0bad));
    branchRow(branchOp(32'h1b8, execPkg::branchEqual, 5'd1, 5'd2, 32'h20), 1'b0, 32'h0);
    branchRow(branchOp(32'h1bc, execPkg::branchNotEqual, 5'd1, 5'd2, 32'h20), 1'b1, 32'h1dc);
    killedRow(loadOp(32'h1c0, 5'd7, 32'h0000_0bad));
    branchRow(branchOp(32'h1dc, execPkg::branchNotEqual, 5'd2, 5'd2, 32'h20), 1'b0, 32'h0);
    branchRow(branchOp(32'h1e0, execPkg::branchLessThan, 5'd1, 5'd2, 32'h20), 1'b1, 32'h200);
    killedRow(loadOp(32'h1e4, 5'd7, 32'h0000_0bad));
    branchRow(branchOp(32'h200, execPkg::branchLessThan, 5'd2, 5'd1, 32'h20), 1'b0, 32'h0);
    branchRow(branchOp(32'h204, execPkg::branchGreaterEqual, 5'd2, 5'd1, 32'h20), 1'b1, 32'h224);
    killedRow(loadOp(32'h208, 5'd7, 32'h0000_0bad));
    branchRow(branchOp(32'h224, execPkg::branchGreaterEqual, 5'd1, 5'd2, 32'h20), 1'b0, 32'h0);
    branchRow(branchOp(32'h228, execPkg::branchUnsignedLessThan, 5'd2, 5'd1, 32'h20), 1'b1,
              32'h248);
    killedRow(loadOp(32'h22c, 5'd7, 32'h0000_0bad));
    branchRow(branchOp(32'h248, execPkg::branchUnsignedLessThan, 5'd1, 5'd2, 32'h20), 1'b0,
              32'h0);
    branchRow(branchOp(32'h24c, execPkg::branchUnsignedGreaterEqual, 5'd1, 5'd2, 32'h20), 1'b1,
              32'h26c);
    killedRow(loadOp(32'h250, 5'd7, 32'h0000_0bad));
    branchRow(branchOp(32'h26c, execPkg::branchUnsignedGreaterEqual, 5'd2, 5'd1, 32'h20), 1'b0,
              32'h0);
    branchRow(branchOp(32'h270, execPkg::branchAlways, 5'd0, 5'd0, 32'hffff_fff0), 1'b1, 32'h260);
    killedRow(loadOp(32'h274, 5'd7, 32'h0000_0bad));
    // link writes pc plus 4, x7 must still hold the slt result
    pushRow(linkOp(32'h260, 5'd9, 32'h40), 1'b1, 32'h0000_0264, 1'b1, 32'h2a0);
    killedRow(loadOp(32'h264, 5'd7, 32'h0000_0bad));
    resultRow(regOp(32'h2a0, execPkg::aluAdd, 5'd10, 5'd9, 5'd7), 32'h0000_0265);
endtask

// ==== tbExecCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbExecCore;

    localparam int StallTimeout = 100;
    localparam int RetireTimeout = 200;

    typedef struct packed {
        execPkg::op_t op;
        logic expectRetire;
        execPkg::word_t value;
        logic taken;
        execPkg::word_t target;
    } vector_t;

    logic clk;
    logic rstN;
    logic issueValid;
    execPkg::op_t issueOp;
    logic stall;
    execPkg::retire_t retire;

    vector_t vectors[$];
    // table rows that must show up on retire in order
    int expectIdx[$];
    int retireCount = 0;
    int failCount = 0;

    execCore i_execCore (
        .clk(clk),
        .rstN(rstN),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .stall(stall),
        .retire(retire)
    );

    always #50 clk = ~clk;

    task automatic abortRun();
        failCount++;
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportMismatch(string name, execPkg::word_t got, execPkg::word_t want);
        $display("[FAIL] %s = 0x%h, expected 0x%h", name, got, want);
        abortRun();
    endtask

    task automatic reportProblem(string msg);
        $display("%s", msg);
        abortRun();
    endtask

    function automatic execPkg::op_t loadOp(execPkg::word_t pc, execPkg::regAddr_t dst,
                                            execPkg::word_t imm);
        execPkg::op_t op;
        op = '0;
        op.aluSrc1 = execPkg::aluSrc1Zero;
        op.aluSrc2 = execPkg::aluSrc2Imm;
        op.regWrite = 1'b1;
        op.imm = imm;
        op.pc = pc;
        op.dst = dst;
        return op;
    endfunction

    function automatic execPkg::op_t immOp(execPkg::word_t pc, execPkg::aluOp_e aluOp,
                                           execPkg::regAddr_t dst, execPkg::regAddr_t src1,
                                           execPkg::word_t imm);
        execPkg::op_t op;
        op = loadOp(pc, dst, imm);
        op.aluOp = aluOp;
        op.aluSrc1 = execPkg::aluSrc1Reg;
        op.src1 = src1;
        return op;
    endfunction

    function automatic execPkg::op_t regOp(execPkg::word_t pc, execPkg::aluOp_e aluOp,
                                           execPkg::regAddr_t dst, execPkg::regAddr_t src1,
                                           execPkg::regAddr_t src2);
        execPkg::op_t op;
        op = immOp(pc, aluOp, dst, src1, 32'h0);
        op.aluSrc2 = execPkg::aluSrc2Reg;
        op.src2 = src2;
        return op;
    endfunction

    function automatic execPkg::op_t mdOp(execPkg::word_t pc, execPkg::mulDivOp_e kind,
                                          execPkg::regAddr_t dst, execPkg::regAddr_t src1,
                                          execPkg::regAddr_t src2);
        execPkg::op_t op;
        op = regOp(pc, execPkg::aluAdd, dst, src1, src2);
        op.resultSrc = execPkg::resultMulDiv;
        op.mulDivOp = kind;
        return op;
    endfunction

    // target comes from the alu as pc plus imm
    function automatic execPkg::op_t branchOp(execPkg::word_t pc, execPkg::branchType_e kind,
                                              execPkg::regAddr_t src1, execPkg::regAddr_t src2,
                                              execPkg::word_t imm);
        execPkg::op_t op;
        op = '0;
        op.aluSrc1 = execPkg::aluSrc1Pc;
        op.aluSrc2 = execPkg::aluSrc2Imm;
        op.isBranch = 1'b1;
        op.branchType = kind;
        op.imm = imm;
        op.pc = pc;
        op.src1 = src1;
        op.src2 = src2;
        return op;
    endfunction

    function automatic execPkg::op_t linkOp(execPkg::word_t pc, execPkg::regAddr_t dst,
                                            execPkg::word_t imm);
        execPkg::op_t op;
        op = branchOp(pc, execPkg::branchAlways, 5'd0, 5'd0, imm);
        op.resultSrc = execPkg::resultNextPc;
        op.regWrite = 1'b1;
        op.dst = dst;
        return op;
    endfunction

    task automatic pushRow(execPkg::op_t op, logic expectRetire, execPkg::word_t value,
                           logic taken, execPkg::word_t target);
        vectors.push_back(vector_t'{op, expectRetire, value, taken, target});
    endtask

    task automatic resultRow(execPkg::op_t op, execPkg::word_t value);
        pushRow(op, 1'b1, value, 1'b0, 32'h0);
    endtask

    task automatic branchRow(execPkg::op_t op, logic taken, execPkg::word_t target);
        pushRow(op, 1'b1, 32'h0, taken, target);
    endtask

    task automatic killedRow(execPkg::op_t op);
        pushRow(op, 1'b0, 32'h0, 1'b0, 32'h0);
    endtask

    `include "tbVectors.svh"

    task automatic checkRetire();
        vector_t row;
        assert (retireCount < expectIdx.size())
            else reportProblem("a retire arrived after every expected row had retired");
        row = vectors[expectIdx[retireCount]];
        assert (retire.pc == row.op.pc)
            else reportMismatch("retire.pc", retire.pc, row.op.pc);
        assert (retire.dst == row.op.dst)
            else reportMismatch("retire.dst", 32'(retire.dst), 32'(row.op.dst));
        assert (retire.regWrite == row.op.regWrite)
            else reportMismatch("retire.regWrite", 32'(retire.regWrite), 32'(row.op.regWrite));
        if (row.op.regWrite) begin
            assert (retire.value == row.value)
                else reportMismatch("retire.value", retire.value, row.value);
        end
        assert (retire.branchTaken == row.taken)
            else reportMismatch("retire.branchTaken", 32'(retire.branchTaken), 32'(row.taken));
        if (row.taken) begin
            assert (retire.branchTarget == row.target)
                else reportMismatch("retire.branchTarget", retire.branchTarget, row.target);
        end
        retireCount++;
    endtask

    // each retire record is checked mid-cycle
    always @(negedge clk) begin
        if (rstN && retire.valid) begin
            checkRetire();
        end
    end

    initial begin
        int waitCycles;
        clk = 1'b0;
        rstN = 1'b0;
        issueValid = 1'b0;
        issueOp = '0;
        loadTable();
        foreach (vectors[i]) begin
            if (vectors[i].expectRetire) begin
                expectIdx.push_back(i);
            end
        end

        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        assert (retire.valid == 1'b0)
            else reportMismatch("retire.valid", 32'(retire.valid), 32'h0);
        assert (stall == 1'b0)
            else reportMismatch("stall", 32'(stall), 32'h0);

        foreach (vectors[i]) begin
            @(posedge clk);
            issueValid <= 1'b1;
            issueOp <= vectors[i].op;
            // the row is taken on the next rising edge with stall low
            waitCycles = 0;
            @(negedge clk);
            while (stall) begin
                waitCycles++;
                assert (waitCycles <= StallTimeout)
                    else reportProblem("stall stayed high too long while an issue was held");
                @(negedge clk);
            end
        end
        @(posedge clk);
        issueValid <= 1'b0;

        waitCycles = 0;
        while (retireCount < expectIdx.size()) begin
            waitCycles++;
            assert (waitCycles <= RetireTimeout)
                else reportProblem("not every expected operation retired in time");
            @(negedge clk);
        end
        // idle cycles so a stray late retire is still caught
        repeat (4) @(negedge clk);

        if (failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
execPkg.sv
regFile.sv
regReadStage.sv
mulDivUnit.sv
executeStage.sv
execCore.sv
tbExecCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbExecCore -f filelist.f

./obj_dir/VtbExecCore > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a pass verdict"
    exit 1
fi
echo "simulation passed"
